// File: src.f
+incdir+source
source/stream_mux_pkg.sv
source/axis_skid.sv
source/packet_arbiter.sv
source/stream_mux.sv
verification/tb_stream_mux.sv

// File: Bender.yml
package:
  name: stream_mux

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/stream_mux_pkg.sv
      - source/axis_skid.sv
      - source/packet_arbiter.sv
      - source/stream_mux.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_stream_mux.sv

// File: verification/tb_stream_mux.sv
`default_nettype none

`include "stream_mux_defs.svh"

module tb_stream_mux;

  import stream_mux_pkg::*;

  localparam int PORTS         = `STREAM_PORTS;
  localparam int MAX_LEN       = 6;
  localparam int PKTS_SINGLE   = 20;
  localparam int PKTS_MIXED    = 30;
  localparam int PKTS_RR       = 12;
  localparam int RESET_CYCLES  = 10;
  localparam int HOLD_CYCLES   = 60;
  localparam int STABLE_CYCLES = 20;
  localparam int TOTAL_BEATS   = MAX_LEN * (PKTS_SINGLE + PORTS * PKTS_MIXED + PORTS * PKTS_RR);
  localparam int TIMEOUT       = 20 * TOTAL_BEATS + 200;

  localparam int SINK_READY  = 0;
  localparam int SINK_RANDOM = 1;
  localparam int SINK_STALL  = 2;

  logic              clock;
  logic              reset;
  logic [PORTS-1:0]  in_valid;
  logic [PORTS-1:0]  in_ready;
  beat_t             in_beat [PORTS];
  logic              out_valid;
  logic              out_ready;
  beat_t             out_beat;

  integer            seed = 32'h26a2_d61c;
  string             test_name;
  int                sink_mode;
  int                only_source;
  bit                rr_check;
  int                cycle_count;
  int                sent_count;
  int                recv_count;

  // Beats per source that went in and have not come out yet.
  beat_t             exp_q [PORTS][$];

  bit                in_packet;
  int                packet_src;
  int                prev_src;
  int                src;
  beat_t             held_beat;
  logic [PORTS-1:0]  taken;

  stream_mux u_dut (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  // ----------------------------------------------------------
  // Helpers.
  // ----------------------------------------------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("MISMATCH %s expected %0h actual %0h",
                                  name, expected, actual));
    end
  endtask

  // Output beat carries the input data and last flag and is tagged with its port.
  function automatic beat_t expected_beat(input int k);
    beat_t b;
    b = exp_q[k][0];
    b.source = source_t'(k);
    return b;
  endfunction

  function automatic int queued_beats();
    int n;
    n = 0;
    for (int k = 0; k < PORTS; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  task automatic wait_drained();
    while (queued_beats() != 0) begin
      @(negedge clock);
    end
    repeat (4) @(posedge clock);
  endtask

  // Entered just after a rising edge. Packets of 1 to MAX_LEN beats.
  task automatic run_source(input int k, input int packets, input bit gaps);
    logic [31:0] rnd;
    int          len;
    beat_t       b;
    for (int p = 0; p < packets; p++) begin
      rnd = $random(seed);
      len = 1 + int'(rnd % MAX_LEN);
      for (int i = 0; i < len; i++) begin
        rnd = $random(seed);
        if (gaps && rnd[1:0] == 2'b00) begin
          in_valid[k] <= 1'b0;
          @(posedge clock);
        end
        rnd = $random(seed);
        b.data   = rnd[`STREAM_WIDTH-1:0];
        b.last   = (i == len - 1);
        // Junk source bits that the mux must overwrite.
        b.source = rnd[30:29];
        in_valid[k] <= 1'b1;
        in_beat[k]  <= b;
        do begin
          @(negedge clock);
        end while (!in_ready[k]);
        exp_q[k].push_back(b);
        sent_count++;
        @(posedge clock);
      end
    end
    in_valid[k] <= 1'b0;
  endtask

  // ----------------------------------------------------------
  // Clock, sink and watchdog.
  // ----------------------------------------------------------

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    forever begin
      @(posedge clock);
      case (sink_mode)
        SINK_READY:  out_ready <= 1'b1;
        SINK_RANDOM: out_ready <= ($random(seed) & 3) != 0;
        default:     out_ready <= 1'b0;
      endcase
    end
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clock);
      cycle_count++;
      if (cycle_count >= TIMEOUT) begin
        stop_with_failure($sformatf("ERROR: timeout after %0d cycles in test %s",
                                    cycle_count, test_name));
      end
    end
  end

  // ----------------------------------------------------------
  // Output comparison.
  // ----------------------------------------------------------

  // Handshake values are stable at the falling edge. The transfer is at the next rise.
  initial begin
    forever begin
      @(negedge clock);
      if (reset) begin
        in_packet = 1'b0;
        prev_src  = PORTS - 1;
      end else if (out_valid && out_ready) begin
        src = int'(out_beat.source);
        if (only_source >= 0) begin
          check_value({test_name, " source"}, only_source, src);
        end
        if (in_packet) begin
          check_value({test_name, " interleave"}, packet_src, src);
        end else if (rr_check) begin
          check_value({test_name, " round robin"}, (prev_src + 1) % PORTS, src);
        end
        if (exp_q[src].size() == 0) begin
          stop_with_failure($sformatf("ERROR: beat from source %0d came out but was never sent",
                                      src));
        end
        check_value({test_name, " beat"}, expected_beat(src), out_beat);
        void'(exp_q[src].pop_front());
        recv_count++;
        if (out_beat.last) begin
          in_packet = 1'b0;
          prev_src  = src;
        end else begin
          in_packet  = 1'b1;
          packet_src = src;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Test sequence.
  // ----------------------------------------------------------

  initial begin
    reset       = 1'b1;
    in_valid    = '0;
    out_ready   = 1'b0;
    sink_mode   = SINK_STALL;
    only_source = -1;
    rr_check    = 1'b0;
    sent_count  = 0;
    recv_count  = 0;
    test_name   = "reset";
    for (int k = 0; k < PORTS; k++) begin
      in_beat[k] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    // One source alone with the sink always ready.
    @(negedge clock);
    test_name   = "single_source";
    only_source = 0;
    sink_mode   = SINK_READY;
    @(posedge clock);
    run_source(0, PKTS_SINGLE, 1'b0);
    wait_drained();

    // All sources with idle gaps and random back-pressure.
    @(negedge clock);
    test_name   = "random_backpressure";
    only_source = -1;
    sink_mode   = SINK_RANDOM;
    @(posedge clock);
    fork
      run_source(0, PKTS_MIXED, 1'b1);
      run_source(1, PKTS_MIXED, 1'b1);
      run_source(2, PKTS_MIXED, 1'b1);
      run_source(3, PKTS_MIXED, 1'b1);
    join
    wait_drained();

    // Long stall and then a reset with beats still inside.
    @(negedge clock);
    test_name = "stall_reset";
    sink_mode = SINK_STALL;
    @(posedge clock);
    for (int k = 0; k < PORTS; k++) begin
      in_valid[k] <= 1'b1;
      in_beat[k]  <= '{data: `STREAM_WIDTH'(8'ha0 + 16 * k), last: 1'b0, source: source_t'(k)};
    end
    // Each accepted beat steps the data so that held beats differ.
    repeat (HOLD_CYCLES) begin
      @(negedge clock);
      taken = in_ready;
      @(posedge clock);
      for (int k = 0; k < PORTS; k++) begin
        if (taken[k]) begin
          in_beat[k] <= '{data: in_beat[k].data + 1'b1, last: 1'b0, source: source_t'(k)};
        end
      end
    end
    @(negedge clock);
    check_value({test_name, " out_valid held"}, 1, out_valid);
    check_value({test_name, " in_ready low"}, 0, in_ready);
    held_beat = out_beat;
    repeat (STABLE_CYCLES) begin
      @(negedge clock);
      check_value({test_name, " out_valid stable"}, 1, out_valid);
      check_value({test_name, " out_beat stable"}, held_beat, out_beat);
    end
    @(posedge clock);
    reset    <= 1'b1;
    in_valid <= '0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_value({test_name, " out_valid after reset"}, 0, out_valid);
    check_value({test_name, " in_ready after reset"}, 0, in_ready);

    // Every source always has a packet waiting.
    test_name = "round_robin";
    rr_check  = 1'b1;
    sink_mode = SINK_RANDOM;
    @(posedge clock);
    fork
      run_source(0, PKTS_RR, 1'b0);
      run_source(1, PKTS_RR, 1'b0);
      run_source(2, PKTS_RR, 1'b0);
      run_source(3, PKTS_RR, 1'b0);
    join
    wait_drained();
    rr_check = 1'b0;
    @(negedge clock);

    if (out_valid !== 1'b0) begin
      stop_with_failure($sformatf("ERROR: output still valid after %0d of %0d beats came out",
                                  recv_count, sent_count));
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: source/stream_mux.sv
`default_nettype none

`include "stream_mux_defs.svh"

module stream_mux (
  input  logic                     clock,
  input  logic                     reset,

  input  logic [`STREAM_PORTS-1:0] in_valid,
  output logic [`STREAM_PORTS-1:0] in_ready,
  input  stream_mux_pkg::beat_t    in_beat [`STREAM_PORTS],

  output logic                     out_valid,
  input  logic                     out_ready,
  output stream_mux_pkg::beat_t    out_beat
);

  import stream_mux_pkg::*;

  logic [`STREAM_PORTS-1:0] req_valid;
  logic [`STREAM_PORTS-1:0] req_ready;
  beat_t                    req_beat [`STREAM_PORTS];

  logic                     arb_valid;
  logic                     arb_ready;
  beat_t                    arb_beat;

  // ----------------------------------------------------------
  // Input skid buffers.
  // ----------------------------------------------------------

  for (genvar k = 0; k < `STREAM_PORTS; k++) begin : g_input
    beat_t tagged_beat;

    // Source field is tagged with the port index.
    assign tagged_beat = '{
      data:   in_beat[k].data,
      last:   in_beat[k].last,
      source: source_t'(k)
    };

    axis_skid #(
      .BYPASS (1'b0)
    ) u_in_skid (
      .clock   (clock),
      .reset   (reset),
      .s_valid (in_valid[k]),
      .s_ready (in_ready[k]),
      .s_beat  (tagged_beat),
      .m_valid (req_valid[k]),
      .m_ready (req_ready[k]),
      .m_beat  (req_beat[k])
    );
  end

  // ----------------------------------------------------------
  // Arbiter and output register.
  // ----------------------------------------------------------

  packet_arbiter u_arbiter (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_beat  (req_beat),
    .out_valid (arb_valid),
    .out_ready (arb_ready),
    .out_beat  (arb_beat)
  );

  // Keeps the arbiter's combinational paths off the output port.
  axis_skid #(
    .BYPASS (1'b0)
  ) u_out_skid (
    .clock   (clock),
    .reset   (reset),
    .s_valid (arb_valid),
    .s_ready (arb_ready),
    .s_beat  (arb_beat),
    .m_valid (out_valid),
    .m_ready (out_ready),
    .m_beat  (out_beat)
  );

endmodule

`default_nettype wire

// File: source/packet_arbiter.sv
`default_nettype none

`include "stream_mux_defs.svh"

module packet_arbiter (
  input  logic                     clock,
  input  logic                     reset,

  input  logic [`STREAM_PORTS-1:0] req_valid,
  output logic [`STREAM_PORTS-1:0] req_ready,
  input  stream_mux_pkg::beat_t    req_beat [`STREAM_PORTS],

  output logic                     out_valid,
  input  logic                     out_ready,
  output stream_mux_pkg::beat_t    out_beat
);

  import stream_mux_pkg::*;

  arb_state_t state;
  source_t    last_grant;
  source_t    lock_source;

  source_t    rr_pick;
  source_t    grant;
  logic       transfer;
  logic       end_of_packet;

  // ----------------------------------------------------------
  // Grant selection.
  // ----------------------------------------------------------

  // Round robin, nearest valid source after the last grant wins.
  always_comb begin
    rr_pick = source_t'((int'(last_grant) + 1) % `STREAM_PORTS);
    for (int i = `STREAM_PORTS; i >= 1; i--) begin
      if (req_valid[(int'(last_grant) + i) % `STREAM_PORTS]) begin
        rr_pick = source_t'((int'(last_grant) + i) % `STREAM_PORTS);
      end
    end
  end

  assign grant = (state == arb_locked) ? lock_source : rr_pick;

  // ----------------------------------------------------------
  // Steering.
  // ----------------------------------------------------------

  assign out_valid     = req_valid[grant];
  assign transfer      = out_valid && out_ready;
  assign end_of_packet = transfer && req_beat[grant].last;

  always_comb begin
    out_beat        = req_beat[grant];
    out_beat.source = grant;
  end

  // Only the granted source sees the output ready.
  always_comb begin
    req_ready        = '0;
    req_ready[grant] = out_ready;
  end

  // ----------------------------------------------------------
  // Packet lock.
  // ----------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= arb_idle;
      last_grant  <= source_t'(`STREAM_PORTS - 1);
      lock_source <= '0;
    end else begin
      case (state)
        arb_idle: begin
          if (end_of_packet) begin
            // Single beat packet, no lock needed.
            last_grant <= grant;
          end else if (transfer) begin
            state       <= arb_locked;
            lock_source <= grant;
          end
        end

        arb_locked: begin
          if (end_of_packet) begin
            state      <= arb_idle;
            last_grant <= lock_source;
          end
        end

        default: begin
          state <= arb_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Checks.
  // ----------------------------------------------------------

  a_one_ready : assert property (@(posedge clock) disable iff (reset)
    $onehot0(req_ready));

  // No other source may cut into a packet in flight.
  a_grant_held : assert property (@(posedge clock) disable iff (reset)
    (state == arb_locked) && !end_of_packet
      |=> (state == arb_locked) && $stable(grant));

endmodule

`default_nettype wire

// File: source/axis_skid.sv
`default_nettype none

module axis_skid #(
  parameter bit BYPASS = 1'b0
) (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  s_valid,
  output logic                  s_ready,
  input  stream_mux_pkg::beat_t s_beat,

  output logic                  m_valid,
  input  logic                  m_ready,
  output stream_mux_pkg::beat_t m_beat
);

  import stream_mux_pkg::*;

  if (BYPASS) begin : g_bypass

    // Straight through, no state.
    assign m_valid = s_valid;
    assign s_ready = m_ready;
    assign m_beat  = s_beat;

  end else begin : g_skid

    logic  ready_q;
    logic  main_valid;
    logic  temp_valid;
    beat_t main_beat;
    beat_t temp_beat;

    logic  accept;
    logic  main_free;
    logic  main_load_in;
    logic  main_load_temp;
    logic  temp_load;
    logic  temp_valid_next;

    assign s_ready = ready_q;
    assign m_valid = main_valid;
    assign m_beat  = main_beat;

    // ----------------------------------------------------------
    // Control.
    // ----------------------------------------------------------

    assign accept    = s_valid && ready_q;
    assign main_free = !main_valid || m_ready;

    // Temp only ever holds a beat while ready_q is low.
    assign main_load_in   = accept && main_free;
    assign main_load_temp = temp_valid && m_ready;
    assign temp_load      = accept && !main_free;

    assign temp_valid_next = temp_load || (temp_valid && !m_ready);

    always_ff @(posedge clock) begin
      if (reset) begin
        ready_q    <= 1'b0;
        main_valid <= 1'b0;
        temp_valid <= 1'b0;
      end else begin
        ready_q    <= !temp_valid_next;
        main_valid <= accept || temp_valid || (main_valid && !m_ready);
        temp_valid <= temp_valid_next;
      end
    end

    // ----------------------------------------------------------
    // Datapath.
    // ----------------------------------------------------------

    always_ff @(posedge clock) begin
      if (main_load_in) begin
        main_beat <= s_beat;
      end else if (main_load_temp) begin
        main_beat <= temp_beat;
      end

      if (temp_load) begin
        temp_beat <= s_beat;
      end
    end

    // ----------------------------------------------------------
    // Checks.
    // ----------------------------------------------------------

    // A stalled output beat is held until it transfers.
    a_beat_stable : assert property (@(posedge clock) disable iff (reset)
      main_valid && !m_ready |=> main_valid && $stable(main_beat));

    // Registered ready must keep the temp register from being overwritten.
    a_temp_no_overwrite : assert property (@(posedge clock) disable iff (reset)
      temp_load |-> !temp_valid);

  end

endmodule

`default_nettype wire

// File: source/stream_mux_pkg.sv
`default_nettype none

`include "stream_mux_defs.svh"

package stream_mux_pkg;

  // ----------------------------------------------------------
  // Beat format.
  // ----------------------------------------------------------

  // Index of an input source.
  typedef logic [$clog2(`STREAM_PORTS)-1:0] source_t;

  // One beat of a packet. Source is filled in by the mux.
  typedef struct packed {
    logic [`STREAM_WIDTH-1:0] data;
    logic                     last;
    source_t                  source;
  } beat_t;

  // ----------------------------------------------------------
  // Arbiter.
  // ----------------------------------------------------------

  // Idle picks a new source, locked holds it until the last beat.
  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_t;

endpackage

`default_nettype wire

// File: source/stream_mux_defs.svh
`ifndef STREAM_MUX_DEFS_SVH
`define STREAM_MUX_DEFS_SVH

// ----------------------------------------------------------
// Stream geometry.
// ----------------------------------------------------------

// Data bits carried by one beat.
`define STREAM_WIDTH 8

// Number of peer input sources.
`define STREAM_PORTS 4

`endif
